/* common/vdp_pkg.sv */
package vdp_pkg;

    ////////////////////
    // Horizontal timing in vclk cycles
    ////////////////////
    localparam logic [9:0] h_total      = 10'd800;
    localparam logic [9:0] h_active     = 10'd640;
    localparam logic [9:0] h_sync_start = 10'd656;
    localparam logic [9:0] h_sync_end   = 10'd752;

    // Vertical timing in scan lines
    localparam logic [9:0] line_total   = 10'd525;
    localparam logic [9:0] line_active  = 10'd480;
    localparam logic [9:0] v_sync_start = 10'd490;
    localparam logic [9:0] v_sync_end   = 10'd492;

    ////////////////////
    // Cell area bounds, hpos and vpos units
    ////////////////////
    localparam logic [9:0] border_left   = 10'd32;
    localparam logic [9:0] border_right  = 10'd608;
    localparam logic [8:0] border_top    = 9'd20;
    localparam logic [8:0] border_bottom = 9'd220;

    localparam int cell_cols = 36;
    localparam int cell_w    = 16;
    localparam int cell_h    = 8;

    localparam logic [8:0] vblank_line = 9'd220;

    // Counter to pins latency
    localparam int pipe_depth = 4;

    // Access codes, top two bits of the command word
    localparam logic [1:0] code_vram_rd = 2'd0;
    localparam logic [1:0] code_vram_wr = 2'd1;
    localparam logic [1:0] code_reg_wr  = 2'd2;
    localparam logic [1:0] code_pal_wr  = 2'd3;

    // Display register indices
    localparam logic [3:0] reg_mode0   = 4'd0;
    localparam logic [3:0] reg_mode1   = 4'd1;
    localparam logic [3:0] reg_scrmap  = 4'd2;
    localparam logic [3:0] reg_sprattr = 4'd5;
    localparam logic [3:0] reg_sprpat  = 4'd6;
    localparam logic [3:0] reg_border  = 4'd7;
    localparam logic [3:0] reg_hscroll = 4'd8;
    localparam logic [3:0] reg_vscroll = 4'd9;
    localparam logic [3:0] reg_raster  = 4'd10;

    ////////////////////
    // Command word, address setup or register write
    ////////////////////
    typedef union packed {
        struct packed {
            logic [1:0]  code;
            logic [13:0] addr;
        } cmd;
        struct packed {
            logic [1:0] code;
            logic [1:0] unused;
            logic [3:0] idx;
            logic [7:0] data;
        } regw;
    } vdp_cmd_u;

    typedef struct packed {
        logic       vscroll_inhibit;
        logic       hscroll_inhibit;
        logic       left_col_blank;
        logic       line_irq_en;
        logic       sprite_shift;
        logic       screen_en;
        logic       vblank_irq_en;
        logic       spr_h16;
        logic       spr_mag;
        logic [7:0] scrmap_base;
        logic [7:0] sprattr_base;
        logic [7:0] sprpat_base;
        logic [7:0] border_idx;
        logic [7:0] hscroll;
        logic [7:0] vscroll;
        logic [7:0] raster_line;
    } vdp_cfg_t;

    typedef struct packed {
        logic [9:0] hpos;
        logic [8:0] vpos;
        logic       hsync;
        logic       vsync;
        logic       blank;
        logic       line_start;
    } vid_pos_t;

endpackage

/* hdl/vram.sv */
`timescale 1ns/1ps

module vram (
    input  logic        vclk,
    input  logic [13:0] cpu_addr,
    input  logic [7:0]  cpu_wrdata,
    input  logic        cpu_wren,
    output logic [7:0]  cpu_rddata,
    input  logic [13:0] vid_addr,
    output logic [7:0]  vid_rddata
);

    logic [7:0] mem [16384];

    // CPU side, read returns the old byte on a write
    always_ff @(posedge vclk) begin
        if (cpu_wren)
            mem[cpu_addr] <= cpu_wrdata;
        cpu_rddata <= mem[cpu_addr];
    end

    // Video side, read only
    always_ff @(posedge vclk) begin
        vid_rddata <= mem[vid_addr];
    end

endmodule

/* hdl/vdp_regs.sv */
`timescale 1ns/1ps

module vdp_regs (
    input  logic              vclk,
    input  logic              reset,
    input  logic              reg_wr,
    input  logic [3:0]        reg_idx,
    input  logic [7:0]        reg_data,
    output vdp_pkg::vdp_cfg_t cfg
);
    import vdp_pkg::*;

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            cfg <= '0;
        end else if (reg_wr) begin
            case (reg_idx)
                reg_mode0: begin
                    cfg.vscroll_inhibit <= reg_data[7];
                    cfg.hscroll_inhibit <= reg_data[6];
                    cfg.left_col_blank  <= reg_data[5];
                    cfg.line_irq_en     <= reg_data[4];
                    cfg.sprite_shift    <= reg_data[3];
                end
                reg_mode1: begin
                    cfg.screen_en     <= reg_data[6];
                    cfg.vblank_irq_en <= reg_data[5];
                    cfg.spr_h16       <= reg_data[1];
                    cfg.spr_mag       <= reg_data[0];
                end
                reg_scrmap:  cfg.scrmap_base  <= reg_data;
                reg_sprattr: cfg.sprattr_base <= reg_data;
                reg_sprpat:  cfg.sprpat_base  <= reg_data;
                reg_border:  cfg.border_idx   <= reg_data;
                reg_hscroll: cfg.hscroll      <= reg_data;
                reg_vscroll: cfg.vscroll      <= reg_data;
                reg_raster:  cfg.raster_line  <= reg_data;
                // Registers 3, 4 and above 10 are not implemented
                default: ;
            endcase
        end
    end

endmodule

/* hdl/vdp_port.sv */
`timescale 1ns/1ps

module vdp_port (
    input  logic              vclk,
    input  logic              reset,
    input  logic              io_portsel,
    input  logic [7:0]        io_wrdata,
    input  logic              io_wren,
    input  logic              io_rddone,
    output logic [7:0]        io_rddata,
    output logic              irq,
    input  vdp_pkg::vdp_cfg_t cfg,
    input  vdp_pkg::vid_pos_t pos,
    output logic [13:0]       vram_addr,
    output logic [7:0]        vram_wrdata,
    output logic              vram_wren,
    input  logic [7:0]        vram_rddata,
    output logic              pal_wren,
    output logic [4:0]        pal_addr,
    output logic              reg_wr,
    output logic [3:0]        reg_idx,
    output logic [7:0]        reg_data
);
    import vdp_pkg::*;

    vdp_cmd_u cmd_q;
    vdp_cmd_u cmd_exec;
    logic     second_byte;
    logic     vblank_pend;
    logic     line_pend;
    logic     rd_valid;
    logic     ctrl_write;
    logic     ctrl_rddone;
    logic     data_write;
    logic     data_rddone;
    logic     vblank_hit;
    logic     line_hit;

    assign ctrl_write  = io_wren   &&  io_portsel;
    assign ctrl_rddone = io_rddone &&  io_portsel;
    assign data_write  = io_wren   && !io_portsel;
    assign data_rddone = io_rddone && !io_portsel;

    // Second byte on top of the latched first byte
    assign cmd_exec = {io_wrdata, cmd_q[7:0]};

    assign vblank_hit = pos.line_start && pos.vpos == vblank_line && cfg.vblank_irq_en;
    assign line_hit   = pos.line_start && pos.vpos == {1'b0, cfg.raster_line} && cfg.line_irq_en;

    ////////////////////
    // Command latch and pending flags
    ////////////////////
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            cmd_q       <= '0;
            second_byte <= 1'b0;
            vblank_pend <= 1'b0;
            line_pend   <= 1'b0;
            rd_valid    <= 1'b0;
        end else begin
            // Read data is stale for one cycle after any address change
            rd_valid <= !(ctrl_write || data_write || data_rddone);

            if (ctrl_write) begin
                if (!second_byte)
                    cmd_q[7:0] <= io_wrdata;
                else if (cmd_exec.cmd.code != code_reg_wr)
                    cmd_q <= cmd_exec;
                second_byte <= !second_byte;
            end else if (data_write || data_rddone) begin
                second_byte    <= 1'b0;
                cmd_q.cmd.addr <= cmd_q.cmd.addr + 14'd1;
            end else if (ctrl_rddone) begin
                second_byte <= 1'b0;
                vblank_pend <= 1'b0;
                line_pend   <= 1'b0;
            end

            // New events win over a clear in the same cycle
            if (vblank_hit)
                vblank_pend <= 1'b1;
            if (line_hit)
                line_pend <= 1'b1;
        end
    end

    assign irq = vblank_pend || line_pend;

    always_comb begin
        if (io_portsel)
            io_rddata = {vblank_pend, line_pend, 6'd0};
        else if (rd_valid)
            io_rddata = vram_rddata;
        else
            io_rddata = 8'd0;
    end

    // Write strobes
    assign vram_addr   = cmd_q.cmd.addr;
    assign vram_wrdata = io_wrdata;
    assign vram_wren   = data_write && cmd_q.cmd.code != code_pal_wr;
    assign pal_wren    = data_write && cmd_q.cmd.code == code_pal_wr;
    assign pal_addr    = cmd_q.cmd.addr[4:0];

    assign reg_wr   = ctrl_write && second_byte && cmd_exec.regw.code == code_reg_wr;
    assign reg_idx  = cmd_exec.regw.idx;
    assign reg_data = cmd_exec.regw.data;

    // Write and read-done strobes never overlap on the CPU bus
    a_strobes_apart: assert property (@(posedge vclk) disable iff (reset)
        !(io_wren && io_rddone));

endmodule

/* video/video_timing.sv */
`timescale 1ns/1ps

module video_timing (
    input  logic              vclk,
    input  logic              reset,
    output vdp_pkg::vid_pos_t pos
);
    import vdp_pkg::*;

    logic [9:0] hpos_q;
    logic [9:0] line_q;
    logic       h_last;
    logic       line_last;

    assign h_last    = hpos_q == h_total - 10'd1;
    assign line_last = line_q == line_total - 10'd1;

    ////////////////////
    // Counters
    ////////////////////
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            hpos_q <= 10'd0;
            line_q <= 10'd0;
        end else if (h_last) begin
            hpos_q <= 10'd0;
            line_q <= line_last ? 10'd0 : line_q + 10'd1;
        end else begin
            hpos_q <= hpos_q + 10'd1;
        end
    end

    ////////////////////
    // Sync and blank
    ////////////////////
    always_comb begin
        pos.hpos       = hpos_q;
        // Every line shown twice
        pos.vpos       = line_q[9:1];
        pos.hsync      = !(hpos_q >= h_sync_start && hpos_q < h_sync_end);
        pos.vsync      = !(line_q >= v_sync_start && line_q < v_sync_end);
        pos.blank      = hpos_q >= h_active || line_q >= line_active;
        pos.line_start = hpos_q == 10'd0;
    end

    a_hpos_range: assert property (@(posedge vclk) disable iff (reset)
        hpos_q < h_total);

endmodule

/* video/palette.sv */
`timescale 1ns/1ps

module palette (
    input  logic       vclk,
    input  logic       reset,
    input  logic       pal_wren,
    input  logic [4:0] pal_addr,
    input  logic [7:0] pal_wrdata,
    input  logic [4:0] pal_idx,
    output logic [5:0] pal_rgb
);

    // RRGGBB
    logic [5:0] ram [32];

    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                ram[i] <= 6'd0;
            pal_rgb <= 6'd0;
        end else begin
            if (pal_wren)
                ram[pal_addr] <= pal_wrdata[5:0];
            pal_rgb <= ram[pal_idx];
        end
    end

endmodule

/* video/pixel_pipe.sv */
`timescale 1ns/1ps

module pixel_pipe (
    input  logic              vclk,
    input  logic              reset,
    input  vdp_pkg::vid_pos_t pos,
    input  vdp_pkg::vdp_cfg_t cfg,
    output logic [13:0]       vid_addr,
    input  logic [7:0]        vid_rddata,
    output logic [4:0]        pal_idx,
    input  logic [5:0]        pal_rgb,
    output logic [9:0]        hcnt,
    output logic [8:0]        vcnt,
    output logic [3:0]        vga_r,
    output logic [3:0]        vga_g,
    output logic [3:0]        vga_b,
    output logic              vga_hsync,
    output logic              vga_vsync
);
    import vdp_pkg::*;

    vid_pos_t   pos_d [pipe_depth];
    logic [9:0] hrel;
    logic [8:0] vrel;
    logic [5:0] col;
    logic [4:0] row;
    logic       in_cell;
    logic       in_cell_q;
    logic       in_cell_qq;

    ////////////////////
    // Stage 1, cell lookup
    ////////////////////
    assign hrel    = pos.hpos - border_left;
    assign vrel    = pos.vpos - border_top;
    assign col     = 6'(hrel / cell_w);
    assign row     = 5'(vrel / cell_h);
    assign in_cell = pos.hpos >= border_left && pos.hpos < border_right &&
                     pos.vpos >= border_top  && pos.vpos < border_bottom;

    // 2 KB map pages, 64 bytes per row
    always_ff @(posedge vclk) begin
        vid_addr <= {cfg.scrmap_base[3:1], row, col};
    end

    // Position delay line, syncs idle high
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < pipe_depth; i++) begin
                pos_d[i]       <= '0;
                pos_d[i].hsync <= 1'b1;
                pos_d[i].vsync <= 1'b1;
            end
            in_cell_q  <= 1'b0;
            in_cell_qq <= 1'b0;
        end else begin
            pos_d[0] <= pos;
            for (int i = 1; i < pipe_depth; i++)
                pos_d[i] <= pos_d[i-1];
            in_cell_q  <= in_cell;
            in_cell_qq <= in_cell_q;
        end
    end

    // Stage 2, VRAM byte is here
    assign pal_idx = (in_cell_qq && cfg.screen_en) ? vid_rddata[4:0] : cfg.border_idx[4:0];

    ////////////////////
    // Stages 3 and 4, colour to pins
    ////////////////////
    always_ff @(posedge vclk or posedge reset) begin
        if (reset) begin
            vga_r <= 4'd0;
            vga_g <= 4'd0;
            vga_b <= 4'd0;
        end else if (pos_d[pipe_depth-2].blank) begin
            vga_r <= 4'd0;
            vga_g <= 4'd0;
            vga_b <= 4'd0;
        end else begin
            vga_r <= {pal_rgb[5:4], pal_rgb[5:4]};
            vga_g <= {pal_rgb[3:2], pal_rgb[3:2]};
            vga_b <= {pal_rgb[1:0], pal_rgb[1:0]};
        end
    end

    assign hcnt      = pos_d[pipe_depth-1].hpos;
    assign vcnt      = pos_d[pipe_depth-1].vpos;
    assign vga_hsync = pos_d[pipe_depth-1].hsync;
    assign vga_vsync = pos_d[pipe_depth-1].vsync;

    a_blank_black: assert property (@(posedge vclk) disable iff (reset)
        pos_d[pipe_depth-1].blank |-> (vga_r == 4'd0 && vga_g == 4'd0 && vga_b == 4'd0));

endmodule

/* hdl/vdp_top.sv */
`timescale 1ns/1ps

module vdp_top (
    input  logic       vclk,
    input  logic       reset,
    input  logic       io_portsel,
    input  logic [7:0] io_wrdata,
    input  logic       io_wren,
    input  logic       io_rddone,
    output logic [7:0] io_rddata,
    output logic       irq,
    output logic [9:0] hcnt,
    output logic [8:0] vcnt,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b,
    output logic       vga_hsync,
    output logic       vga_vsync
);
    import vdp_pkg::*;

    vdp_cfg_t    cfg;
    vid_pos_t    pos;
    logic [13:0] vram_addr;
    logic [7:0]  vram_wrdata;
    logic        vram_wren;
    logic [7:0]  vram_rddata;
    logic        pal_wren;
    logic [4:0]  pal_addr;
    logic        reg_wr;
    logic [3:0]  reg_idx;
    logic [7:0]  reg_data;
    logic [13:0] vid_addr;
    logic [7:0]  vid_rddata;
    logic [4:0]  pal_idx;
    logic [5:0]  pal_rgb;

    ////////////////////
    // CPU side
    ////////////////////
    vdp_port vdp_port_inst (
        .vclk, .reset,
        .io_portsel, .io_wrdata, .io_wren, .io_rddone, .io_rddata, .irq,
        .cfg, .pos,
        .vram_addr, .vram_wrdata, .vram_wren, .vram_rddata,
        .pal_wren, .pal_addr,
        .reg_wr, .reg_idx, .reg_data
    );

    vdp_regs vdp_regs_inst (
        .vclk, .reset, .reg_wr, .reg_idx, .reg_data, .cfg
    );

    vram vram_inst (
        .vclk,
        .cpu_addr   (vram_addr),
        .cpu_wrdata (vram_wrdata),
        .cpu_wren   (vram_wren),
        .cpu_rddata (vram_rddata),
        .vid_addr,
        .vid_rddata
    );

    ////////////////////
    // Video side
    ////////////////////
    video_timing video_timing_inst (
        .vclk, .reset, .pos
    );

    // Palette data shares the CPU write byte
    palette palette_inst (
        .vclk, .reset,
        .pal_wren, .pal_addr,
        .pal_wrdata (vram_wrdata),
        .pal_idx, .pal_rgb
    );

    pixel_pipe pixel_pipe_inst (
        .vclk, .reset, .pos, .cfg,
        .vid_addr, .vid_rddata,
        .pal_idx, .pal_rgb,
        .hcnt, .vcnt,
        .vga_r, .vga_g, .vga_b, .vga_hsync, .vga_vsync
    );

endmodule

/* test/vdp_tb.sv */
`timescale 1ns/1ps

module vdp_tb;
    import vdp_pkg::*;

    typedef enum logic [2:0] {
        op_ctrl_wr,
        op_data_wr,
        op_data_rd,
        op_ctrl_rd,
        op_pixel,
        op_wait_irq
    } step_op_e;

    typedef struct {
        string       name;
        step_op_e    op;
        logic [31:0] value;
    } step_t;

    localparam longint frame_ns = longint'(h_total) * longint'(line_total) * 4;

    logic       vclk = 1'b0;
    logic       reset;
    logic       io_portsel;
    logic [7:0] io_wrdata;
    logic       io_wren;
    logic       io_rddone;
    logic [7:0] io_rddata;
    logic       irq;
    logic [9:0] hcnt;
    logic [8:0] vcnt;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;
    logic       vga_hsync;
    logic       vga_vsync;

    step_t       steps [$];
    logic        table_ready = 1'b0;
    logic [31:0] rng_state = 32'h898c;

    // Reference model of the CPU port state
    logic        second_model;
    logic [7:0]  low_model;
    logic [13:0] addr_model;
    logic [1:0]  code_model;
    logic [7:0]  reg_model [16];
    logic [7:0]  vram_model [16384];
    logic [5:0]  pal_model [32];

    vdp_top vdp_top_inst (
        .vclk, .reset,
        .io_portsel, .io_wrdata, .io_wren, .io_rddone, .io_rddata, .irq,
        .hcnt, .vcnt,
        .vga_r, .vga_g, .vga_b, .vga_hsync, .vga_vsync
    );

    always #2 vclk = ~vclk;

    task automatic check_equal(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    ////////////////////
    // Reference models
    ////////////////////
    function automatic logic [13:0] cell_address(int h, int v, logic [7:0] scrmap);
        int a;
        a = int'(scrmap[3:1]) * 2048
            + ((v - int'(border_top)) / cell_h) * 64
            + (h - int'(border_left)) / cell_w;
        return 14'(a);
    endfunction

    function automatic logic [3:0] widen(logic [1:0] c);
        return 4'(c) * 4'd5;
    endfunction

    function automatic logic [11:0] colour_at(int h, int v);
        logic [4:0] idx;
        logic [5:0] rgb;
        logic       in_cells;
        in_cells = h >= 32 && h < 608 && v >= 20 && v < 220;
        if (reg_model[1][6] && in_cells)
            idx = vram_model[cell_address(h, v, reg_model[2])][4:0];
        else
            idx = reg_model[7][4:0];
        rgb = pal_model[idx];
        // Blank covers columns from 640 and scan lines from 480
        if (h >= 640 || v >= 240)
            return 12'd0;
        else
            return {widen(rgb[5:4]), widen(rgb[3:2]), widen(rgb[1:0])};
    endfunction

    ////////////////////
    // Table building
    ////////////////////
    task automatic push_step(string name, step_op_e op, logic [31:0] value);
        step_t s;
        s.name  = name;
        s.op    = op;
        s.value = value;
        steps.push_back(s);
    endtask

    task automatic address_setup(string name, logic [1:0] code, logic [13:0] addr);
        push_step({name, " lo"}, op_ctrl_wr, 32'(addr[7:0]));
        push_step({name, " hi"}, op_ctrl_wr, 32'({code, addr[13:8]}));
    endtask

    task automatic register_write(string name, logic [3:0] idx, logic [7:0] data);
        push_step({name, " lo"}, op_ctrl_wr, 32'(data));
        push_step({name, " hi"}, op_ctrl_wr, 32'({2'b10, 2'b00, idx}));
    endtask

    task automatic pixel_step(string name, logic [9:0] h, logic [8:0] v);
        push_step(name, op_pixel, 32'({v, h}));
    endtask

    task automatic build_table();
        logic [7:0] block [8];
        int         cell_x [4] = '{32, 100, 300, 607};
        int         cell_y [4] = '{20, 50, 130, 219};
        push_step("idle status", op_ctrl_rd, 32'h00);

        // VRAM block with auto-increment
        address_setup("block wr addr", code_vram_wr, 14'h0123);
        for (int i = 0; i < 8; i++) begin
            rng_state = xorshift32(rng_state);
            block[i] = rng_state[7:0];
            push_step($sformatf("block wr %0d", i), op_data_wr, 32'(block[i]));
        end
        address_setup("block rd addr", code_vram_rd, 14'h0123);
        for (int i = 0; i < 8; i++)
            push_step($sformatf("block rd %0d", i), op_data_rd, 32'(block[i]));

        // Whole palette
        address_setup("pal addr", code_pal_wr, 14'h0000);
        for (int i = 0; i < 32; i++) begin
            rng_state = xorshift32(rng_state);
            push_step($sformatf("pal wr %0d", i), op_data_wr, 32'(rng_state[7:0]));
        end
        register_write("border idx", reg_border, 8'h0d);
        pixel_step("border pixel", 10'd10, 9'd100);

        ////////////////////
        // Cell area
        ////////////////////
        register_write("scrmap", reg_scrmap, 8'h06);
        for (int k = 0; k < 4; k++) begin
            address_setup($sformatf("cell %0d addr", k), code_vram_wr,
                          cell_address(cell_x[k], cell_y[k], 8'h06));
            rng_state = xorshift32(rng_state);
            push_step($sformatf("cell %0d wr", k), op_data_wr, 32'(rng_state[7:0]));
        end
        register_write("screen on", reg_mode1, 8'h40);
        for (int k = 0; k < 4; k++)
            pixel_step($sformatf("cell %0d on", k), 10'(cell_x[k]), 9'(cell_y[k]));
        pixel_step("border with screen", 10'd10, 9'd100);
        register_write("screen off", reg_mode1, 8'h00);
        for (int k = 0; k < 4; k++)
            pixel_step($sformatf("cell %0d off", k), 10'(cell_x[k]), 9'(cell_y[k]));

        // Blank and sync edges
        pixel_step("last active", 10'd639, 9'd100);
        pixel_step("first blank", 10'd640, 9'd100);
        pixel_step("before hsync", 10'd655, 9'd100);
        pixel_step("hsync start", 10'd656, 9'd100);
        pixel_step("hsync end", 10'd751, 9'd100);
        pixel_step("after hsync", 10'd752, 9'd100);
        pixel_step("blank row", 10'd300, 9'd250);
        pixel_step("before vsync", 10'd100, 9'd244);
        pixel_step("in vsync", 10'd100, 9'd245);
        pixel_step("after vsync", 10'd100, 9'd246);

        ////////////////////
        // Interrupts
        ////////////////////
        register_write("raster line", reg_raster, 8'd60);
        register_write("line irq on", reg_mode0, 8'h10);
        push_step("line irq", op_wait_irq, 32'd0);
        push_step("line status", op_ctrl_rd, 32'h40);
        register_write("line irq off", reg_mode0, 8'h00);
        register_write("vblank irq on", reg_mode1, 8'h20);
        push_step("vblank irq", op_wait_irq, 32'd0);
        push_step("vblank status", op_ctrl_rd, 32'h80);
        register_write("vblank irq off", reg_mode1, 8'h00);
    endtask

    ////////////////////
    // Bus operations
    ////////////////////
    task automatic control_write(logic [7:0] val);
        io_portsel = 1'b1;
        io_wrdata  = val;
        io_wren    = 1'b1;
        @(posedge vclk);
        #1;
        io_wren = 1'b0;
        if (!second_model) begin
            // First byte lands in the low half of the command word
            low_model       = val;
            addr_model[7:0] = val;
        end else if (val[7:6] == code_reg_wr) begin
            reg_model[val[3:0]] = low_model;
        end else begin
            code_model = val[7:6];
            addr_model = {val[5:0], low_model};
        end
        second_model = !second_model;
    endtask

    task automatic data_write(logic [7:0] val);
        io_portsel = 1'b0;
        io_wrdata  = val;
        io_wren    = 1'b1;
        @(posedge vclk);
        #1;
        io_wren = 1'b0;
        if (code_model == code_pal_wr)
            pal_model[addr_model[4:0]] = val[5:0];
        else
            vram_model[addr_model] = val;
        addr_model   = addr_model + 14'd1;
        second_model = 1'b0;
    endtask

    task automatic data_read(string name, logic [7:0] expected);
        io_portsel = 1'b0;
        // Data is valid two cycles after the last address change
        repeat (2) begin
            @(posedge vclk);
            #1;
        end
        check_equal(name, 32'(expected), 32'(io_rddata));
        io_rddone = 1'b1;
        @(posedge vclk);
        #1;
        io_rddone    = 1'b0;
        addr_model   = addr_model + 14'd1;
        second_model = 1'b0;
    endtask

    task automatic control_read(string name, logic [7:0] expected);
        io_portsel = 1'b1;
        @(posedge vclk);
        #1;
        check_equal({name, " status"}, 32'(expected), 32'(io_rddata));
        io_rddone = 1'b1;
        @(posedge vclk);
        #1;
        io_rddone    = 1'b0;
        second_model = 1'b0;
        check_equal({name, " irq clear"}, 32'd0, 32'(irq));
    endtask

    task automatic pixel_check(string name, logic [31:0] value);
        logic [9:0] h;
        logic [8:0] v;
        h = value[9:0];
        v = value[18:10];
        // Let earlier register writes reach the pins
        repeat (pipe_depth + 2) @(posedge vclk);
        #1;
        while (hcnt != h || vcnt != v) begin
            @(posedge vclk);
            #1;
        end
        check_equal({name, " colour"}, 32'(colour_at(int'(h), int'(v))),
                    32'({vga_r, vga_g, vga_b}));
        // Hsync low for columns 656 through 751
        check_equal({name, " hsync"}, 32'(h < 10'd656 || h > 10'd751),
                    32'(vga_hsync));
        check_equal({name, " vsync"}, 32'(v != 9'(v_sync_start >> 1)), 32'(vga_vsync));
    endtask

    task automatic irq_wait();
        while (!irq) begin
            @(posedge vclk);
            #1;
        end
    endtask

    ////////////////////
    // Watchdog
    ////////////////////
    initial begin
        longint limit_ns;
        wait (table_ready);
        limit_ns = longint'(steps.size()) * 2 * frame_ns;
        #(limit_ns);
        $display("Watchdog expired after %0d ns, the DUT stopped responding", limit_ns);
        $display("Errors found");
        $fatal(1);
    end

    initial begin
        reset      = 1'b1;
        io_portsel = 1'b0;
        io_wrdata  = 8'd0;
        io_wren    = 1'b0;
        io_rddone  = 1'b0;
        second_model = 1'b0;
        low_model    = 8'd0;
        addr_model   = 14'd0;
        code_model   = 2'd0;
        foreach (reg_model[i])
            reg_model[i] = 8'd0;
        foreach (pal_model[i])
            pal_model[i] = 6'd0;
        build_table();
        table_ready = 1'b1;

        repeat (2) @(posedge vclk);
        #1;
        check_equal("reset irq", 32'd0, 32'(irq));
        check_equal("reset rddata", 32'd0, 32'(io_rddata));
        check_equal("reset hcnt", 32'd0, 32'(hcnt));
        check_equal("reset vcnt", 32'd0, 32'(vcnt));
        check_equal("reset colour", 32'd0, 32'({vga_r, vga_g, vga_b}));
        check_equal("reset syncs", 32'd3, 32'({vga_hsync, vga_vsync}));
        reset = 1'b0;

        foreach (steps[i]) begin
            case (steps[i].op)
                op_ctrl_wr:  control_write(steps[i].value[7:0]);
                op_data_wr:  data_write(steps[i].value[7:0]);
                op_data_rd:  data_read(steps[i].name, steps[i].value[7:0]);
                op_ctrl_rd:  control_read(steps[i].name, steps[i].value[7:0]);
                op_pixel:    pixel_check(steps[i].name, steps[i].value);
                op_wait_irq: irq_wait();
                default: ;
            endcase
        end

        $display("No errors");
        $finish;
    end

endmodule

/* list.f */
common/vdp_pkg.sv
hdl/vram.sv
hdl/vdp_regs.sv
hdl/vdp_port.sv
video/video_timing.sv
video/palette.sv
video/pixel_pipe.sv
hdl/vdp_top.sv
test/vdp_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= vdp_tb
FLIST     ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= No errors

SOURCES := $(shell grep -v '^+' $(FLIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
